//--- src/sink_macros.svh
// ------------------------------
// store streamer build constants
// widths, port count, FIFO depth
// ------------------------------

`ifndef SINK_MACROS_SVH
`define SINK_MACROS_SVH

// byte address width of the memory side
`define SINK_ADDR_WIDTH 32

// number of 32-bit memory ports fed in parallel
`define SINK_NB_PORTS 2

// one stream word covers one lane per port
`define SINK_DATA_WIDTH (32 * `SINK_NB_PORTS)

// entries in each per-port store FIFO
`define SINK_FIFO_DEPTH 2

// width of word count, line length and stride
`define SINK_CNT_WIDTH 16

`endif

//--- src/sink_pkg.sv
// ------------------------------
// store streamer shared types
// ------------------------------

`default_nettype none

`include "sink_macros.svh"

package sink_pkg;

  typedef logic [`SINK_ADDR_WIDTH-1:0] addr_t;        // byte address
  typedef logic [31:0]                 lane_t;        // one memory word
  typedef logic [`SINK_DATA_WIDTH-1:0] stream_word_t; // one full stream word
  typedef logic [3:0]                  be_t;          // byte enables of one port
  typedef logic [`SINK_CNT_WIDTH-1:0]  cnt_t;         // counts and stride

  // controller FSM
  typedef enum logic {
    SINK_IDLE,    // waiting for start
    SINK_WORKING  // streaming and draining
  } sink_state_e;

endpackage

`default_nettype wire

//--- src/sink_addressgen.sv
// ------------------------------
// sink address generator
// walks a 2d store pattern and
// gives the lane 0 address per word
// ------------------------------

`default_nettype none

`include "sink_macros.svh"

module sink_addressgen
  import sink_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  load_i,        // latch new pattern
  input  logic  advance_i,     // one stream word taken
  input  addr_t base_i,
  input  cnt_t  words_i,
  input  cnt_t  line_len_i,
  input  cnt_t  line_stride_i,
  output addr_t addr_o,        // address of next word
  output logic  in_progress_o  // words still to come
);

  localparam int unsigned STEP = 4 * `SINK_NB_PORTS; // bytes per stream word

  cnt_t  words_q, line_len_q, stride_q; // programmed pattern
  cnt_t  col_q, word_q;                 // position in line and in job
  cnt_t  col_nxt, word_nxt;
  addr_t line_base_q;                   // start address of current line
  addr_t col_off_q;                     // byte offset within the line
  logic  in_progress_q;
  logic  step;
  logic  line_end;

  assign step     = advance_i & in_progress_q;
  assign col_nxt  = col_q + 1'b1;
  assign word_nxt = word_q + 1'b1;
  assign line_end = (col_nxt == line_len_q); // last column of this line

  // counters and progress flag
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      col_q         <= '0;
      word_q        <= '0;
      in_progress_q <= 1'b0;
    end else if (load_i) begin
      col_q         <= '0;
      word_q        <= '0;
      in_progress_q <= (words_i != '0); // empty job never runs
    end else if (step) begin
      word_q <= word_nxt;
      col_q  <= line_end ? '0 : col_nxt;
      if (word_nxt == words_q) begin
        in_progress_q <= 1'b0;            // last word just went out
      end
    end
  end

  // pattern and address registers
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      words_q     <= words_i;
      line_len_q  <= line_len_i;
      stride_q    <= line_stride_i;
      line_base_q <= base_i;
      col_off_q   <= '0;
    end else if (step) begin
      if (line_end) begin
        line_base_q <= line_base_q + addr_t'(stride_q); // jump to next line
        col_off_q   <= '0;
      end else begin
        col_off_q <= col_off_q + addr_t'(STEP);
      end
    end
  end

  assign addr_o        = line_base_q + col_off_q;
  assign in_progress_o = in_progress_q;

endmodule

`default_nettype wire

//--- src/sink_ctrl.sv
// ------------------------------
// sink controller
// idle/working FSM, start and
// done pulse after full drain
// ------------------------------

`default_nettype none

`include "sink_macros.svh"

module sink_ctrl
  import sink_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      start_i,
  input  logic                      in_progress_i, // generator still has words
  input  logic                      issue_busy_i,  // issue register holds a word
  input  logic [`SINK_NB_PORTS-1:0] fifo_empty_i,  // one flag per store FIFO
  output logic                      ready_start_o,
  output logic                      load_o,        // load pattern into generator
  output logic                      working_o,
  output logic                      done_o
);

  sink_state_e state_q, state_d;
  logic        drained;
  logic        done_d;
  logic        done_q;

  // nothing left anywhere in the pipe and no req up
  assign drained = ~in_progress_i & ~issue_busy_i & (&fifo_empty_i);

  always_comb begin
    state_d = state_q;
    load_o  = 1'b0;
    done_d  = 1'b0;
    case (state_q)
      SINK_IDLE: begin
        if (start_i) begin
          load_o  = 1'b1;          // config sampled on this edge
          state_d = SINK_WORKING;
        end
      end
      SINK_WORKING: begin
        if (drained) begin
          state_d = SINK_IDLE;
          done_d  = 1'b1;
        end
      end
      default: begin
        state_d = SINK_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SINK_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;   // single cycle pulse
    end
  end

  assign ready_start_o = (state_q == SINK_IDLE);
  assign working_o     = (state_q == SINK_WORKING);
  assign done_o        = done_q;

endmodule

`default_nettype wire

//--- src/sink_store_issue.sv
// ------------------------------
// store issue stage
// holds one stream word and splits
// it into per-port stores
// ------------------------------

`default_nettype none

`include "sink_macros.svh"

module sink_store_issue
  import sink_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      working_i,
  input  logic                      in_progress_i,
  input  logic                      stream_valid_i,
  input  stream_word_t              stream_data_i,
  input  addr_t                     addr_i,       // lane 0 address of next word
  input  logic [`SINK_NB_PORTS-1:0] push_ready_i,
  output logic                      stream_ready_o,
  output logic                      accepted_o,   // stream handshake this cycle
  output logic                      issue_busy_o,
  output logic [`SINK_NB_PORTS-1:0] push_valid_o,
  output addr_t                     push_add_o  [`SINK_NB_PORTS],
  output lane_t                     push_data_o [`SINK_NB_PORTS]
);

  logic         full_q;   // register holds a word
  stream_word_t data_q;
  addr_t        addr_q;
  logic         all_ready;
  logic         push_fire;

  assign all_ready = &push_ready_i;        // every FIFO has room
  assign push_fire = full_q & all_ready;   // all lanes leave together

  assign stream_ready_o = working_i & in_progress_i & (~full_q | all_ready);
  assign accepted_o     = stream_valid_i & stream_ready_o;
  assign issue_busy_o   = full_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (accepted_o) begin
      full_q <= 1'b1;                      // refill even while draining
    end else if (push_fire) begin
      full_q <= 1'b0;
    end
  end

  // payload follows the handshake
  always_ff @(posedge clk_i) begin
    if (accepted_o) begin
      data_q <= stream_data_i;
      addr_q <= addr_i;
    end
  end

  for (genvar p = 0; p < `SINK_NB_PORTS; p++) begin : gen_lanes
    assign push_valid_o[p] = push_fire;
    assign push_add_o[p]   = addr_q + addr_t'(4 * p);  // lane offset in bytes
    assign push_data_o[p]  = data_q[32*p +: 32];
  end

endmodule

`default_nettype wire

//--- src/sink_store_fifo.sv
// ------------------------------
// per-port store FIFO
// head entry is the memory req,
// a grant pops it
// ------------------------------

`default_nettype none

`include "sink_macros.svh"

module sink_store_fifo
  import sink_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  push_valid_i,
  input  addr_t push_add_i,
  input  lane_t push_data_i,
  input  logic  mem_gnt_i,
  output logic  push_ready_o,
  output logic  empty_o,
  output logic  mem_req_o,
  output addr_t mem_add_o,
  output be_t   mem_be_o,
  output lane_t mem_data_o
);

  localparam int unsigned DEPTH = `SINK_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  addr_t            add_mem  [DEPTH];  // store addresses
  lane_t            data_mem [DEPTH];  // store data
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             push, pop;

  assign push_ready_o = (cnt_q != FULL_CNT);  // no push through on full
  assign empty_o      = (cnt_q == '0);
  assign push         = push_valid_i & push_ready_o;
  assign pop          = mem_req_o & mem_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      add_mem[wr_ptr_q]  <= push_add_i;
      data_mem[wr_ptr_q] <= push_data_i;
    end
  end

  assign mem_req_o  = ~empty_o;             // req held until granted
  assign mem_add_o  = add_mem[rd_ptr_q];
  assign mem_data_o = data_mem[rd_ptr_q];
  assign mem_be_o   = '1;                   // always full-word stores

endmodule

`default_nettype wire

//--- src/stream_sink.sv
// ------------------------------
// stream sink top
// stream words in, 2d-patterned
// word stores out on req/gnt ports
// ------------------------------

`default_nettype none

`include "sink_macros.svh"

module stream_sink
  import sink_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      start_i,
  input  addr_t                     base_i,
  input  cnt_t                      words_i,
  input  cnt_t                      line_len_i,
  input  cnt_t                      line_stride_i,
  output logic                      ready_start_o,
  output logic                      done_o,
  input  logic                      stream_valid_i,
  input  stream_word_t              stream_data_i,
  output logic                      stream_ready_o,
  output logic [`SINK_NB_PORTS-1:0] mem_req_o,
  output addr_t                     mem_add_o  [`SINK_NB_PORTS],
  output be_t                       mem_be_o   [`SINK_NB_PORTS],
  output lane_t                     mem_data_o [`SINK_NB_PORTS],
  input  logic [`SINK_NB_PORTS-1:0] mem_gnt_i
);

  logic                      load, working;
  logic                      in_progress, accepted, issue_busy;
  addr_t                     gen_addr;
  logic [`SINK_NB_PORTS-1:0] push_valid, push_ready, fifo_empty;
  addr_t                     push_add  [`SINK_NB_PORTS];
  lane_t                     push_data [`SINK_NB_PORTS];

  sink_ctrl i_ctrl (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .start_i       ( start_i       ),
    .in_progress_i ( in_progress   ),
    .issue_busy_i  ( issue_busy    ),
    .fifo_empty_i  ( fifo_empty    ),
    .ready_start_o ( ready_start_o ),
    .load_o        ( load          ),
    .working_o     ( working       ),
    .done_o        ( done_o        )
  );

  sink_addressgen i_addressgen (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .load_i        ( load          ),
    .advance_i     ( accepted      ),
    .base_i        ( base_i        ),
    .words_i       ( words_i       ),
    .line_len_i    ( line_len_i    ),
    .line_stride_i ( line_stride_i ),
    .addr_o        ( gen_addr      ),
    .in_progress_o ( in_progress   )
  );

  sink_store_issue i_issue (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .working_i      ( working        ),
    .in_progress_i  ( in_progress    ),
    .stream_valid_i ( stream_valid_i ),
    .stream_data_i  ( stream_data_i  ),
    .addr_i         ( gen_addr       ),
    .push_ready_i   ( push_ready     ),
    .stream_ready_o ( stream_ready_o ),
    .accepted_o     ( accepted       ),
    .issue_busy_o   ( issue_busy     ),
    .push_valid_o   ( push_valid     ),
    .push_add_o     ( push_add       ),
    .push_data_o    ( push_data      )
  );

  // one store FIFO per memory port
  for (genvar p = 0; p < `SINK_NB_PORTS; p++) begin : gen_ports
    sink_store_fifo i_fifo (
      .clk_i        ( clk_i         ),
      .rst_ni       ( rst_ni        ),
      .push_valid_i ( push_valid[p] ),
      .push_add_i   ( push_add[p]   ),
      .push_data_i  ( push_data[p]  ),
      .mem_gnt_i    ( mem_gnt_i[p]  ),
      .push_ready_o ( push_ready[p] ),
      .empty_o      ( fifo_empty[p] ),
      .mem_req_o    ( mem_req_o[p]  ),
      .mem_add_o    ( mem_add_o[p]  ),
      .mem_be_o     ( mem_be_o[p]   ),
      .mem_data_o   ( mem_data_o[p] )
    );
  end

endmodule

`default_nettype wire

//--- bench/tb_mem_model.sv
// ------------------------------
// testbench memory model
// random grants, byte-wide store
// ------------------------------

`default_nettype none

`include "sink_macros.svh"

module tb_mem_model
  import sink_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,      // wipe memory and grant count
  input  logic [`SINK_NB_PORTS-1:0] req_i,
  input  addr_t                     add_i  [`SINK_NB_PORTS],
  input  be_t                       be_i   [`SINK_NB_PORTS],
  input  lane_t                     data_i [`SINK_NB_PORTS],
  output logic [`SINK_NB_PORTS-1:0] gnt_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [7:0]  mem [addr_t];  // sparse byte memory
  int unsigned gnt_count;     // granted stores since last clear

  initial begin
    gnt_o     = '0;
    gnt_count = 0;
  end

  // req and gnt are stable here, the store lands on the next edge
  always @(negedge clk_i) begin
    if (clear_i) begin
      mem.delete();
      gnt_count = 0;
    end
    for (int p = 0; p < `SINK_NB_PORTS; p++) begin
      if (req_i[p] && gnt_o[p]) begin
        for (int b = 0; b < 4; b++) begin
          if (be_i[p][b]) begin
            mem[add_i[p] + addr_t'(b)] = data_i[p][8*b +: 8]; // little endian lanes
          end
        end
        gnt_count++;
      end
    end
  end

  // coin flip per port, a little after the edge
  always @(posedge clk_i) begin
    #1;
    for (int p = 0; p < `SINK_NB_PORTS; p++) begin
      gnt_o[p] = rst_ni & 1'($urandom_range(0, 1));
    end
  end

  // {written, value} of one byte
  function automatic logic [8:0] byte_at(input addr_t a);
    if (mem.exists(a)) begin
      return {1'b1, mem[a]};
    end
    return 9'h000;
  endfunction

  function automatic int unsigned bytes_written();
    return mem.num();
  endfunction

  function automatic int unsigned grant_total();
    return gnt_count;
  endfunction

endmodule

`default_nettype wire

//--- bench/tb_stream_sink.sv
// ------------------------------
// stream sink testbench
// random 2d jobs checked against
// the address rule, with watchdog
// ------------------------------

`default_nettype none

`include "sink_macros.svh"

module tb_stream_sink
  import sink_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NB         = `SINK_NB_PORTS;
  localparam int JOBS       = 40;
  localparam int JOB_CYCLES = 400;   // generous bound per job
  localparam int SEED       = 88484;

  logic         clk, rst_n, start, mem_clear;
  addr_t        cfg_base;
  cnt_t         cfg_words, cfg_len, cfg_stride;
  logic         ready_start, done, stream_valid, stream_ready;
  stream_word_t stream_data;
  logic [NB-1:0] mem_req, mem_gnt;
  addr_t        mem_add  [NB];
  be_t          mem_be   [NB];
  lane_t        mem_data [NB];

  stream_word_t job_words [$];     // words of the running job
  int           errors;
  int           n_words, len, stride;
  addr_t        base_addr;

  stream_sink UUT (
    .clk_i (clk), .rst_ni (rst_n), .start_i (start), .base_i (cfg_base),
    .words_i (cfg_words), .line_len_i (cfg_len), .line_stride_i (cfg_stride),
    .ready_start_o (ready_start), .done_o (done), .stream_valid_i (stream_valid),
    .stream_data_i (stream_data), .stream_ready_o (stream_ready), .mem_req_o (mem_req),
    .mem_add_o (mem_add), .mem_be_o (mem_be), .mem_data_o (mem_data), .mem_gnt_i (mem_gnt)
  );

  tb_mem_model i_mem (
    .clk_i (clk), .rst_ni (rst_n), .clear_i (mem_clear), .req_i (mem_req),
    .add_i (mem_add), .be_i (mem_be), .data_i (mem_data), .gnt_o (mem_gnt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;          // 20 ns period
  end

  initial begin
    #((JOBS * JOB_CYCLES + 20) * 20);
    $display("timeout: the jobs did not finish in time");
    $display("Something failed");
    $finish;
  end

  // lane p of word k: line k/len, column k%len
  function automatic addr_t lane_addr(input addr_t b, input int k, input int l,
                                      input int s, input int p);
    return b + addr_t'((k / l) * s + (k % l) * 4 * NB + 4 * p);
  endfunction

  task automatic report(input string msg);
    errors++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  task automatic run_job(input addr_t b, input int n, input int l, input int s);
    stream_word_t w;
    int           k;
    logic         fire;
    logic         seen_done;
    job_words.delete();
    for (int i = 0; i < n; i++) begin
      for (int p = 0; p < NB; p++) begin
        w[32*p +: 32] = $urandom;
      end
      job_words.push_back(w);
    end
    @(posedge clk);
    #1;
    start = 1'b1;
    mem_clear = 1'b1;                // fresh memory for every job
    cfg_base = b;
    cfg_words = cnt_t'(n);
    cfg_len = cnt_t'(l);
    cfg_stride = cnt_t'(s);
    @(negedge clk);
    assert (ready_start && !done) else report("start not accepted or stray done");
    @(posedge clk);
    #1;
    start = 1'b0;
    mem_clear = 1'b0;
    cfg_base = ~b;                   // config must have been latched
    stream_valid = 1'b0;
    k = 0;
    fire = 1'b0;
    seen_done = 1'b0;
    while (!seen_done) begin
      if (fire || !stream_valid) begin  // data held while stalled
        if (k < n) begin
          stream_valid = 1'($urandom_range(0, 1));
          stream_data = job_words[k];
        end else begin
          stream_valid = 1'b1;          // surplus word, must never be taken
        end
      end
      @(negedge clk);
      fire = stream_valid && stream_ready;
      if (fire) begin
        k++;
      end
      assert (k <= n) else report("stream took more words than programmed");
      for (int p = 0; p < NB; p++) begin
        assert (!mem_req[p] || mem_be[p] == 4'hF) else report("byte enables not full");
      end
      if (done) begin
        seen_done = 1'b1;
        assert (ready_start) else report("ready_start low at done");
        assert (k == n && i_mem.grant_total() == n * NB) else report("done before last grant");
      end else begin
        assert (!ready_start) else report("ready_start high while busy");
        @(posedge clk);
        #1;
      end
    end
  endtask

  task automatic check_memory(input addr_t b, input int n, input int l, input int s);
    addr_t a;
    lane_t lane;
    for (int k = 0; k < n; k++) begin
      for (int p = 0; p < NB; p++) begin
        a = lane_addr(b, k, l, s, p);
        lane = job_words[k][32*p +: 32];
        for (int i = 0; i < 4; i++) begin
          assert (i_mem.byte_at(a + addr_t'(i)) == {1'b1, lane[8*i +: 8]}) else begin
            errors++;
            $display("[FAIL] %0t: byte at %h wrong or missing, expected %h", $time,
                     a + addr_t'(i), lane[8*i +: 8]);
          end
        end
      end
    end
    assert (i_mem.bytes_written() == n * NB * 4) else report("stores outside expected set");
    assert (i_mem.grant_total() == n * NB) else report("wrong number of grants");
  endtask

  initial begin
    void'($urandom(SEED));
    errors = 0;
    rst_n = 1'b0;
    start = 1'b0;
    mem_clear = 1'b0;
    cfg_base = '0;
    cfg_words = '0;
    cfg_len = '0;
    cfg_stride = '0;
    stream_valid = 1'b0;
    stream_data = '0;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    assert (ready_start && !stream_ready && mem_req == '0 && !done)
      else report("outputs not idle after reset");
    for (int j = 0; j < JOBS; j++) begin
      n_words = $urandom_range(1, 40);
      len = (j % 5 == 0) ? n_words : $urandom_range(1, 8);  // every fifth job linear
      stride = len * 4 * NB + 4 * $urandom_range(0, 8);
      base_addr = addr_t'($urandom) & 32'h0FFF_FFF8;
      run_job(base_addr, n_words, len, stride);
      check_memory(base_addr, n_words, len, stride);
    end
    @(negedge clk);
    assert (!done) else report("done pulse longer than one cycle");
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+src
src/sink_pkg.sv
src/sink_addressgen.sv
src/sink_ctrl.sv
src/sink_store_issue.sv
src/sink_store_fifo.sv
src/stream_sink.sv
bench/tb_mem_model.sv
bench/tb_stream_sink.sv

//--- Makefile
TOP := tb_stream_sink

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	  -f build.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Everything OK"

lint:
	verilator --lint-only --timing -Wall --timescale 1ns/1ps \
	  -f build.f --top-module stream_sink

clean:
	rm -rf obj_dir
